//--- logic/frame_config.svh
`ifndef FRAME_CONFIG_SVH
`define FRAME_CONFIG_SVH

// Video widths
`define FRAME_GAME_COLOR_W 4   // Per channel, as the game core drives it
`define FRAME_VGA_COLOR_W  6   // Per channel, towards the VGA connector

// Audio sample width
`define FRAME_SND_W 16

// Board joystick word
// Direction, buttons, coin, start and pause
`define FRAME_JOY_W 10

// Cycles of game reset after the last cause goes away
`define FRAME_RST_HOLD 16

`endif

//--- logic/frame_video_pkg.sv
`include "frame_config.svh"

package frame_video_pkg;

    // One colour channel from the game core
    typedef logic [`FRAME_GAME_COLOR_W-1:0] game_color_t;

    // One colour channel at the VGA output
    typedef logic [`FRAME_VGA_COLOR_W-1:0] vga_color_t;

    // Captured pixel after blanking
    typedef struct packed {
        game_color_t r;
        game_color_t g;
        game_color_t b;
        logic        hs;
        logic        vs;
    } pixel_t;

    // Result of one colour channel stage
    typedef struct packed {
        vga_color_t color;
        logic       valid;   // One cycle per pixel
    } chan_out_t;

endpackage

//--- logic/frame_ctrl_pkg.sv
`include "frame_config.svh"

package frame_ctrl_pkg;

    typedef logic [`FRAME_SND_W-1:0] snd_sample_t;

    // Board joystick word, active high
    // Declared MSB first, so dir sits in bits 3:0
    typedef struct packed {
        logic       pause;
        logic       start;
        logic       coin;
        logic [2:0] button;
        logic [3:0] dir;      // Up, down, left, right
    } board_joy_t;

    // Buttons and directions as the game expects them, active low
    typedef logic [`FRAME_JOY_W-4:0] game_joy_t;

    // Game reset sequencing
    typedef enum logic [1:0] {
        RST_ACTIVE,
        RST_HOLD,
        RST_IDLE
    } rst_state_t;

endpackage

//--- logic/frame_reset_gen.sv
`include "frame_config.svh"

module frame_reset_gen (
    input  logic clk_rgb,
    input  logic reset,
    input  logic dip_flip,
    input  logic rst_req,
    input  logic downloading,
    output logic game_rst
);

    localparam int CNT_W = $clog2(`FRAME_RST_HOLD);

    frame_ctrl_pkg::rst_state_t state;
    logic [CNT_W-1:0]           hold_cnt;
    logic                       flip_r;
    logic                       cause;

    // Any flip of the screen restarts the game
    always_ff @(posedge clk_rgb) begin
        flip_r <= dip_flip;
    end

    assign cause = downloading | rst_req | (dip_flip != flip_r);

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            state    <= frame_ctrl_pkg::RST_ACTIVE;
            hold_cnt <= '0;
        end else if (cause) begin
            state    <= frame_ctrl_pkg::RST_ACTIVE;   // Also restarts a running hold
            hold_cnt <= '0;
        end else begin
            case (state)
                frame_ctrl_pkg::RST_ACTIVE: begin
                    state    <= frame_ctrl_pkg::RST_HOLD;
                    hold_cnt <= '0;
                end
                frame_ctrl_pkg::RST_HOLD: begin
                    if (hold_cnt == CNT_W'(`FRAME_RST_HOLD - 1)) begin
                        state <= frame_ctrl_pkg::RST_IDLE;
                    end
                    hold_cnt <= hold_cnt + 1'b1;
                end
                default: begin
                    state <= frame_ctrl_pkg::RST_IDLE;
                end
            endcase
        end
    end

    assign game_rst = (state != frame_ctrl_pkg::RST_IDLE);   // Straight from the state flops

    // Still in reset on the last hold cycle after any cause
    hold_covers_last_cause: assert property (
        @(posedge clk_rgb) $past(reset | cause, `FRAME_RST_HOLD + 1) |-> game_rst
    );

endmodule

//--- logic/frame_pixel_capture.sv
module frame_pixel_capture (
    input  logic                        clk_rgb,
    input  logic                        reset,
    input  logic                        pxl_cen,
    input  frame_video_pkg::game_color_t game_r,
    input  frame_video_pkg::game_color_t game_g,
    input  frame_video_pkg::game_color_t game_b,
    input  logic                        LHBL,
    input  logic                        LVBL,
    input  logic                        hs,
    input  logic                        vs,
    output frame_video_pkg::pixel_t     pixel,
    output logic                        pix_valid
);

    logic blank;

    assign blank = ~LHBL | ~LVBL;   // Either blanking signal is active low

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= pxl_cen;
        end
    end

    // Colour is forced to black during blanking
    always_ff @(posedge clk_rgb) begin
        if (pxl_cen) begin
            pixel.r  <= blank ? '0 : game_r;
            pixel.g  <= blank ? '0 : game_g;
            pixel.b  <= blank ? '0 : game_b;
            pixel.hs <= hs;
            pixel.vs <= vs;
        end
    end

endmodule

//--- logic/frame_color_channel.sv
`include "frame_config.svh"

module frame_color_channel (
    input  logic                         clk_rgb,
    input  logic                         reset,
    input  frame_video_pkg::game_color_t color_in,
    input  logic                         pix_valid,
    input  logic                         en_mixing,
    output frame_video_pkg::chan_out_t   chan_out
);

    localparam int EXTRA_W = `FRAME_VGA_COLOR_W - `FRAME_GAME_COLOR_W;

    frame_video_pkg::vga_color_t expanded;
    frame_video_pkg::vga_color_t prev;      // Last expanded pixel
    frame_video_pkg::vga_color_t result;
    frame_video_pkg::vga_color_t color_r;
    logic [`FRAME_VGA_COLOR_W:0] mix_sum;   // One extra bit for the carry
    logic                        valid_r;

    // Top bits repeated at the bottom so full scale stays full scale
    assign expanded = {color_in, color_in[`FRAME_GAME_COLOR_W-1 -: EXTRA_W]};

    assign mix_sum = {1'b0, expanded} + {1'b0, prev};
    assign result  = en_mixing ? mix_sum[`FRAME_VGA_COLOR_W:1] : expanded;

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            valid_r <= 1'b0;
            prev    <= '0;
        end else begin
            valid_r <= pix_valid;
            if (pix_valid) begin
                prev <= expanded;   // Unmixed value feeds the next blend
            end
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (pix_valid) begin
            color_r <= result;
        end
    end

    assign chan_out.color = color_r;
    assign chan_out.valid = valid_r;

endmodule

//--- logic/frame_video_out.sv
module frame_video_out (
    input  logic                        clk_rgb,
    input  logic                        reset,
    input  frame_video_pkg::chan_out_t  chan_r,
    input  frame_video_pkg::chan_out_t  chan_g,
    input  frame_video_pkg::chan_out_t  chan_b,
    input  frame_video_pkg::pixel_t     pixel,
    input  logic                        pix_valid,
    output frame_video_pkg::vga_color_t vga_r,
    output frame_video_pkg::vga_color_t vga_g,
    output frame_video_pkg::vga_color_t vga_b,
    output logic                        vga_hsync,
    output logic                        vga_vsync
);

    logic hs_d;   // Sync bits, one stage behind the capture
    logic vs_d;

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            hs_d <= 1'b0;
            vs_d <= 1'b0;
        end else if (pix_valid) begin
            hs_d <= pixel.hs;
            vs_d <= pixel.vs;
        end
    end

    // Outputs hold between pixels
    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else if (chan_r.valid) begin
            vga_r     <= chan_r.color;
            vga_g     <= chan_g.color;
            vga_b     <= chan_b.color;
            vga_hsync <= hs_d;
            vga_vsync <= vs_d;
        end
    end

    // Only red's strobe is used, the other channels must agree
    channels_in_step: assert property (
        @(posedge clk_rgb) disable iff (reset)
        (chan_r.valid == chan_g.valid) && (chan_r.valid == chan_b.valid)
    );

endmodule

//--- logic/frame_sound_dac.sv
`include "frame_config.svh"

module frame_sound_dac #(
    parameter bit signed_snd = 1'b0
) (
    input  logic                        clk_rgb,
    input  logic                        reset,
    input  frame_ctrl_pkg::snd_sample_t snd,
    output logic                        snd_pwm
);

    frame_ctrl_pkg::snd_sample_t snd_ob;   // Offset binary
    logic [`FRAME_SND_W:0]       acc;      // Carry on top
    logic [`FRAME_SND_W:0]       sum;

    // Two's complement to offset binary is a flip of the sign bit
    always_comb begin
        snd_ob = snd;
        if (signed_snd) begin
            snd_ob[`FRAME_SND_W-1] = ~snd[`FRAME_SND_W-1];
        end
    end

    // Remainder only, last carry is dropped
    assign sum = {1'b0, acc[`FRAME_SND_W-1:0]} + {1'b0, snd_ob};

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            acc <= '0;
        end else begin
            acc <= sum;
        end
    end

    assign snd_pwm = acc[`FRAME_SND_W];   // Density follows the sample level

endmodule

//--- logic/frame_input_map.sv
module frame_input_map (
    input  logic                       clk_rgb,
    input  logic                       reset,
    input  frame_ctrl_pkg::board_joy_t board_joystick1,
    input  frame_ctrl_pkg::board_joy_t board_joystick2,
    output frame_ctrl_pkg::game_joy_t  game_joystick1,
    output frame_ctrl_pkg::game_joy_t  game_joystick2,
    output logic [1:0]                 game_coin,
    output logic [1:0]                 game_start,
    output logic                       game_pause
);

    logic pause_any;
    logic pause_d;     // Previous pause level for edge detection

    assign pause_any = board_joystick1.pause | board_joystick2.pause;

    // Game inputs are active low
    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            game_joystick1 <= '1;
            game_joystick2 <= '1;
            game_coin      <= '1;
            game_start     <= '1;
        end else begin
            game_joystick1 <= ~{board_joystick1.button, board_joystick1.dir};
            game_joystick2 <= ~{board_joystick2.button, board_joystick2.dir};
            game_coin      <= ~{board_joystick2.coin, board_joystick1.coin};   // P1 in bit 0
            game_start     <= ~{board_joystick2.start, board_joystick1.start};
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            pause_d    <= 1'b0;
            game_pause <= 1'b0;
        end else begin
            pause_d <= pause_any;
            if (pause_any && !pause_d) begin
                game_pause <= ~game_pause;   // Press once to pause, again to resume
            end
        end
    end

endmodule

//--- logic/frame_board_top.sv
module frame_board_top #(
    parameter bit signed_snd = 1'b0
) (
    input  logic                         clk_rgb,
    input  logic                         reset,
    input  logic                         pxl_cen,
    input  frame_video_pkg::game_color_t game_r,
    input  frame_video_pkg::game_color_t game_g,
    input  frame_video_pkg::game_color_t game_b,
    input  logic                         LHBL,
    input  logic                         LVBL,
    input  logic                         hs,
    input  logic                         vs,
    input  logic                         en_mixing,
    input  frame_ctrl_pkg::snd_sample_t  snd,
    input  frame_ctrl_pkg::board_joy_t   board_joystick1,
    input  frame_ctrl_pkg::board_joy_t   board_joystick2,
    input  logic                         dip_flip,
    input  logic                         rst_req,
    input  logic                         downloading,
    output logic                         game_rst,
    output frame_video_pkg::vga_color_t  vga_r,
    output frame_video_pkg::vga_color_t  vga_g,
    output frame_video_pkg::vga_color_t  vga_b,
    output logic                         vga_hsync,
    output logic                         vga_vsync,
    output logic                         snd_pwm,
    output frame_ctrl_pkg::game_joy_t    game_joystick1,
    output frame_ctrl_pkg::game_joy_t    game_joystick2,
    output logic [1:0]                   game_coin,
    output logic [1:0]                   game_start,
    output logic                         game_pause
);

    frame_video_pkg::pixel_t      pixel;
    logic                         pix_valid;
    frame_video_pkg::game_color_t chan_in  [3];   // R, G, B
    frame_video_pkg::chan_out_t   chan_res [3];

    frame_reset_gen u_reset (
        .clk_rgb     ( clk_rgb     ),
        .reset       ( reset       ),
        .dip_flip    ( dip_flip    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .game_rst    ( game_rst    )
    );

    frame_pixel_capture u_capture (
        .clk_rgb   ( clk_rgb   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .LHBL      ( LHBL      ),
        .LVBL      ( LVBL      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .pixel     ( pixel     ),
        .pix_valid ( pix_valid )
    );

    assign chan_in[0] = pixel.r;
    assign chan_in[1] = pixel.g;
    assign chan_in[2] = pixel.b;

    for (genvar i = 0; i < 3; i++) begin : g_chan
        frame_color_channel u_chan (
            .clk_rgb   ( clk_rgb     ),
            .reset     ( reset       ),
            .color_in  ( chan_in[i]  ),
            .pix_valid ( pix_valid   ),
            .en_mixing ( en_mixing   ),
            .chan_out  ( chan_res[i] )
        );
    end

    frame_video_out u_video_out (
        .clk_rgb   ( clk_rgb     ),
        .reset     ( reset       ),
        .chan_r    ( chan_res[0] ),
        .chan_g    ( chan_res[1] ),
        .chan_b    ( chan_res[2] ),
        .pixel     ( pixel       ),
        .pix_valid ( pix_valid   ),
        .vga_r     ( vga_r       ),
        .vga_g     ( vga_g       ),
        .vga_b     ( vga_b       ),
        .vga_hsync ( vga_hsync   ),
        .vga_vsync ( vga_vsync   )
    );

    frame_sound_dac #(.signed_snd(signed_snd)) u_dac (
        .clk_rgb ( clk_rgb ),
        .reset   ( reset   ),
        .snd     ( snd     ),
        .snd_pwm ( snd_pwm )
    );

    frame_input_map u_inputs (
        .clk_rgb         ( clk_rgb         ),
        .reset           ( reset           ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      )
    );

endmodule

//--- bench/frame_board_model.svh
`ifndef FRAME_BOARD_MODEL_SVH
`define FRAME_BOARD_MODEL_SVH

// One predicted VGA update and the step at which it lands
typedef struct packed {
    int                          due;
    frame_video_pkg::vga_color_t r;
    frame_video_pkg::vga_color_t g;
    frame_video_pkg::vga_color_t b;
    logic                        hs;
    logic                        vs;
} vga_entry_t;

vga_entry_t                  pix_q[$];
frame_video_pkg::vga_color_t exp_r, exp_g, exp_b;
logic                        exp_hs, exp_vs;
frame_video_pkg::vga_color_t prev_r, prev_g, prev_b;   // Last expanded pixel
int                          quiet;      // Steps since the last reset cause
logic                        flip_m;
logic [`FRAME_SND_W:0]       acc_m;
frame_ctrl_pkg::game_joy_t   exp_joy1, exp_joy2;
logic [1:0]                  exp_coin, exp_start;
logic                        exp_pause, pause_m;
int                          cyc;

// 4 to 6 bits, top bits repeated below
function automatic frame_video_pkg::vga_color_t expand(input frame_video_pkg::game_color_t c);
    return {c, c[3:2]};
endfunction

function automatic frame_video_pkg::vga_color_t blend(input frame_video_pkg::vga_color_t a,
                                                      input frame_video_pkg::vga_color_t b);
    logic [6:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[6:1];   // Floor of the average
endfunction

task automatic capture_pixel();
    vga_entry_t                  e;
    logic                        blank;
    frame_video_pkg::vga_color_t xr, xg, xb;
    blank = !(LHBL && LVBL);
    xr = blank ? '0 : expand(game_r);
    xg = blank ? '0 : expand(game_g);
    xb = blank ? '0 : expand(game_b);
    e.due = cyc + 3;
    e.r = en_mixing ? blend(xr, prev_r) : xr;
    e.g = en_mixing ? blend(xg, prev_g) : xg;
    e.b = en_mixing ? blend(xb, prev_b) : xb;
    e.hs = hs;
    e.vs = vs;
    prev_r = xr;
    prev_g = xg;
    prev_b = xb;
    pix_q.push_back(e);
endtask

// Advance the model by one clock edge using the inputs that edge samples
task automatic step_model();
    logic           cause;
    logic           pause_any;
    logic [15:0]    ob;
    cause = reset | downloading | rst_req | (dip_flip != flip_m);
    flip_m = dip_flip;
    if (cause) begin
        quiet = 0;
    end else if (quiet <= `FRAME_RST_HOLD) begin
        quiet++;
    end
    ob = snd;
    if (SIGNED_SND) ob[15] = ~snd[15];   // Offset binary
    pause_any = board_joystick1.pause | board_joystick2.pause;
    if (reset) begin
        pix_q.delete();
        {exp_r, exp_g, exp_b, exp_hs, exp_vs} = '0;
        {prev_r, prev_g, prev_b} = '0;
        acc_m = '0;
        exp_joy1 = '1;
        exp_joy2 = '1;
        exp_coin = '1;
        exp_start = '1;
        exp_pause = 1'b0;
        pause_m = 1'b0;
    end else begin
        if (pxl_cen) capture_pixel();
        acc_m = {1'b0, acc_m[15:0]} + {1'b0, ob};
        exp_joy1 = ~{board_joystick1.button, board_joystick1.dir};
        exp_joy2 = ~{board_joystick2.button, board_joystick2.dir};
        exp_coin = ~{board_joystick2.coin, board_joystick1.coin};
        exp_start = ~{board_joystick2.start, board_joystick1.start};
        if (pause_any && !pause_m) exp_pause = ~exp_pause;
        pause_m = pause_any;
    end
    cyc++;
endtask

`endif

//--- bench/frame_board_tb.sv
`include "frame_config.svh"

module frame_board_tb;

    localparam bit SIGNED_SND = 1'b1;
    localparam int CAUSE_LEN = 600;
    localparam int VIDEO_LEN = 2000;
    localparam int SOUND_LEN = 1000;
    localparam int INPUT_LEN = 500;
    localparam int LIMIT = 5 + 30 + CAUSE_LEN + 2 * (VIDEO_LEN + 5) + SOUND_LEN
                           + INPUT_LEN + 10 + 200;

    logic clk_rgb = 1'b1;
    logic reset, pxl_cen, LHBL, LVBL, hs, vs, en_mixing;
    logic dip_flip, rst_req, downloading;
    frame_video_pkg::game_color_t game_r, game_g, game_b;
    frame_ctrl_pkg::snd_sample_t  snd;
    frame_ctrl_pkg::board_joy_t   board_joystick1, board_joystick2;
    logic game_rst, vga_hsync, vga_vsync, snd_pwm, game_pause;
    frame_video_pkg::vga_color_t  vga_r, vga_g, vga_b;
    frame_ctrl_pkg::game_joy_t    game_joystick1, game_joystick2;
    logic [1:0] game_coin, game_start;
    string test_name = "reset";
    bit    primed = 0;
    int    cycles = 0;

    `include "frame_board_model.svh"

    frame_board_top #(.signed_snd(SIGNED_SND)) i_frame_board_top (.*);

    always #50 clk_rgb = ~clk_rgb;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Output mismatch in test %s", test_name);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk_rgb) begin
        if (primed) begin
            while (pix_q.size() > 0 && pix_q[0].due == cyc) begin
                {exp_r, exp_g, exp_b, exp_hs, exp_vs} = {pix_q[0].r, pix_q[0].g, pix_q[0].b,
                                                         pix_q[0].hs, pix_q[0].vs};
                void'(pix_q.pop_front());
            end
            check("game_rst", 32'(quiet <= `FRAME_RST_HOLD), 32'(game_rst));
            check("vga_r", 32'(exp_r), 32'(vga_r));
            check("vga_g", 32'(exp_g), 32'(vga_g));
            check("vga_b", 32'(exp_b), 32'(vga_b));
            check("vga_hsync", 32'(exp_hs), 32'(vga_hsync));
            check("vga_vsync", 32'(exp_vs), 32'(vga_vsync));
            check("snd_pwm", 32'(acc_m[`FRAME_SND_W]), 32'(snd_pwm));
            check("game_joystick1", 32'(exp_joy1), 32'(game_joystick1));
            check("game_joystick2", 32'(exp_joy2), 32'(game_joystick2));
            check("game_coin", 32'(exp_coin), 32'(game_coin));
            check("game_start", 32'(exp_start), 32'(game_start));
            check("game_pause", 32'(exp_pause), 32'(game_pause));
        end
        step_model();
        primed = 1;
    end

    always @(posedge clk_rgb) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Simulation failed");
            $fatal(1, "Timeout: the run went past %0d cycles", LIMIT);
        end
    end

    task automatic run_causes(input int len);
        int dl_left;
        dl_left = 0;
        repeat (len) begin
            @(posedge clk_rgb);
            if (dl_left > 0) begin
                dl_left--;
            end else if ($urandom_range(59, 0) == 0) begin
                dl_left = $urandom_range(10, 1);
            end
            downloading <= (dl_left > 0);
            rst_req <= ($urandom_range(39, 0) == 0);
            if ($urandom_range(49, 0) == 0) dip_flip <= ~dip_flip;
        end
        @(posedge clk_rgb);
        {downloading, rst_req} <= '0;
    endtask

    task automatic run_video(input logic mix, input int len);
        en_mixing <= mix;
        repeat (len) begin
            @(posedge clk_rgb);
            pxl_cen <= ($urandom_range(2, 0) == 0);   // About one pixel in three
            game_r <= 4'($urandom());
            game_g <= 4'($urandom());
            game_b <= 4'($urandom());
            LHBL <= ($urandom_range(7, 0) != 0);
            LVBL <= ($urandom_range(7, 0) != 0);
            hs <= 1'($urandom());
            vs <= 1'($urandom());
        end
        @(posedge clk_rgb);
        pxl_cen <= 1'b0;
        repeat (4) @(posedge clk_rgb);   // Let the pipeline drain before mixing changes
    endtask

    initial begin
        void'($urandom(32'h2134_d41e));
        {reset, pxl_cen, LHBL, LVBL, hs, vs, en_mixing} = 7'b1000000;
        {dip_flip, rst_req, downloading} = '0;
        {game_r, game_g, game_b} = '0;
        snd = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        repeat (5) @(posedge clk_rgb);
        reset <= 1'b0;
        repeat (30) @(posedge clk_rgb);
        test_name = "reset_causes";
        run_causes(CAUSE_LEN);
        test_name = "video_plain";
        run_video(1'b0, VIDEO_LEN);
        test_name = "video_mixing";
        run_video(1'b1, VIDEO_LEN);
        test_name = "sound";
        repeat (SOUND_LEN) begin
            @(posedge clk_rgb);
            snd <= 16'($urandom());
        end
        test_name = "inputs";
        repeat (INPUT_LEN) begin
            @(posedge clk_rgb);
            board_joystick1 <= frame_ctrl_pkg::board_joy_t'(10'($urandom()));
            board_joystick2 <= frame_ctrl_pkg::board_joy_t'(10'($urandom()));
        end
        repeat (5) @(posedge clk_rgb);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
+incdir+bench
logic/frame_video_pkg.sv
logic/frame_ctrl_pkg.sv
logic/frame_reset_gen.sv
logic/frame_pixel_capture.sv
logic/frame_color_channel.sv
logic/frame_video_out.sv
logic/frame_sound_dac.sv
logic/frame_input_map.sv
logic/frame_board_top.sv
bench/frame_board_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module frame_board_tb -f sources.f -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir
